//--- filelist.f
hw/axicb_pkg.sv
hw/axicb_addr_decoder.sv
hw/axicb_sync_fifo.sv
hw/axicb_round_robin.sv
hw/axicb_write_ctrl.sv
hw/axicb_write_switch.sv
test/tb_clock_gen.sv
test/tb_write_switch.sv

//--- hw/axicb_addr_decoder.sv
// Windows are inclusive and must not overlap; a disabled route never matches
// An all-zero mask means the address is undefined or forbidden

`timescale 1ns/1ps

module axicb_addr_decoder #(
    parameter logic [axicb_pkg::SLV_NB*axicb_pkg::ADDR_W-1:0] SLV_START = {
        16'd12288, 16'd8192, 16'd4096, 16'd0
    },
    parameter logic [axicb_pkg::SLV_NB*axicb_pkg::ADDR_W-1:0] SLV_END = {
        16'd16383, 16'd12287, 16'd8191, 16'd4095
    },
    parameter axicb_pkg::slv_mask_t MST_ROUTES = 4'b1111
) (
    input  axicb_pkg::addr_t     i_addr,
    output axicb_pkg::slv_mask_t o_target
);

    localparam int AW = axicb_pkg::ADDR_W;

    ////////////////////
    // Window compare
    ////////////////////

    always_comb begin
        for (int i = 0; i < axicb_pkg::SLV_NB; i++) begin
            o_target[i] = MST_ROUTES[i]
                       && (i_addr >= SLV_START[i*AW +: AW])
                       && (i_addr <= SLV_END[i*AW +: AW]);
        end
    end

    // Overlapping windows would steer one write to two slaves
    always_comb begin
        assert ($onehot0(o_target))
        else $error("address decoder: %h matches several windows", i_addr);
    end

endmodule

//--- hw/axicb_pkg.sv
// Shared widths, response codes and channel types of the write switch
// The slave count of 4 is fixed here and sizes every per-slave vector

package axicb_pkg;

    // Widths
    localparam int SLV_NB = 4;
    localparam int ADDR_W = 16;
    localparam int ID_W   = 4;
    localparam int DATA_W = 32;

    // One bit per slave, set for the targeted slave
    typedef logic [SLV_NB-1:0] slv_mask_t;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [1:0]        resp_t;

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

endpackage

//--- hw/axicb_round_robin.sv
// Equal priorities; a grant stays locked on its requester until i_en
// marks it served, so a pending response is never swapped out

`timescale 1ns/1ps

module axicb_round_robin #(
    parameter int REQ_NB = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              i_en,
    input  logic [REQ_NB-1:0] i_req,
    output logic [REQ_NB-1:0] o_grant
);

    localparam int IDX_W = $clog2(REQ_NB);

    logic [IDX_W-1:0]  last_idx;
    logic [IDX_W-1:0]  grant_idx;
    logic [REQ_NB-1:0] rr_grant;
    logic [REQ_NB-1:0] lock_grant;
    logic              locked;

    ////////////////////
    // Rotating search
    ////////////////////

    // Start right after the last served requester
    always_comb begin : rr_search
        int idx;
        rr_grant = '0;
        for (int k = 1; k <= REQ_NB; k++) begin
            idx = int'(last_idx) + k;
            if (idx >= REQ_NB) begin
                idx = idx - REQ_NB;
            end
            if (i_req[idx] && (rr_grant == '0)) begin
                rr_grant[idx] = 1'b1;
            end
        end
    end

    assign o_grant = (locked && |(lock_grant & i_req)) ? lock_grant : rr_grant;

    always_comb begin
        grant_idx = last_idx;
        for (int i = 0; i < REQ_NB; i++) begin
            if (o_grant[i]) begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            last_idx   <= IDX_W'(REQ_NB - 1);
            locked     <= 1'b0;
            lock_grant <= '0;
        end else if (i_en) begin
            last_idx <= grant_idx;
            locked   <= 1'b0;
        end else begin
            locked     <= |o_grant;
            lock_grant <= o_grant;
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn) $onehot0(o_grant))
    else $error("round robin: several grants");

endmodule

//--- hw/axicb_sync_fifo.sv
// DEPTH must be a power of two, at least 2; no bypass, so data pushed
// in a cycle shows on o_data from the next cycle on

`timescale 1ns/1ps

module axicb_sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pull,
    output payload_t o_data,
    output logic     o_full,
    output logic     o_empty
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;

    ////////////////////
    // Pointers
    ////////////////////

    // Extra MSB tells a full FIFO from an empty one
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                  && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge aclk) begin
        if (i_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= i_data;
        end
    end

    assign o_data = mem[rd_ptr[PTR_W-1:0]];

    // Callers must respect the flags
    assert property (@(posedge aclk) disable iff (!aresetn) i_push |-> !o_full)
    else $error("sync fifo: push while full");

    assert property (@(posedge aclk) disable iff (!aresetn) i_pull |-> !o_empty)
    else $error("sync fifo: pull while empty");

endmodule

//--- hw/axicb_write_ctrl.sv
// AW is offered to a slave only while the routing FIFO has room
// DECERR responses go out before any pending slave response

`timescale 1ns/1ps

module axicb_write_ctrl (
    input  logic                 aclk,
    input  logic                 aresetn,
    // Master side
    input  logic                 i_awvalid,
    input  axicb_pkg::id_t       i_awid,
    input  axicb_pkg::slv_mask_t i_target,
    output logic                 o_awready,
    input  logic                 i_wvalid,
    input  logic                 i_wlast,
    output logic                 o_wready,
    output logic                 o_bvalid,
    input  logic                 i_bready,
    output axicb_pkg::id_t       o_bid,
    output axicb_pkg::resp_t     o_bresp,
    // Slave side
    output axicb_pkg::slv_mask_t o_s_awvalid,
    input  axicb_pkg::slv_mask_t i_s_awready,
    output axicb_pkg::slv_mask_t o_s_wvalid,
    output axicb_pkg::slv_mask_t o_s_wlast,
    input  axicb_pkg::slv_mask_t i_s_wready,
    input  axicb_pkg::slv_mask_t i_s_bvalid,
    output axicb_pkg::slv_mask_t o_s_bready,
    input  logic [axicb_pkg::SLV_NB*axicb_pkg::ID_W-1:0] i_s_bid,
    input  logic [axicb_pkg::SLV_NB*2-1:0]               i_s_bresp,
    // Routing FIFO
    output logic                 o_wfifo_push,
    output logic                 o_wfifo_pull,
    input  logic                 i_wfifo_full,
    input  logic                 i_wfifo_empty,
    input  axicb_pkg::slv_mask_t i_w_target,
    // DECERR ID FIFO
    output logic                 o_bfifo_push,
    output logic                 o_bfifo_pull,
    input  logic                 i_bfifo_full,
    input  logic                 i_bfifo_empty,
    input  axicb_pkg::id_t       i_bfifo_id,
    // Arbiter
    output logic                 o_arb_en,
    input  axicb_pkg::slv_mask_t i_grant
);

    localparam int NB = axicb_pkg::SLV_NB;
    localparam int IW = axicb_pkg::ID_W;

    logic             aw_routed;
    logic             mr_pulse;
    logic             w_active;
    logic             w_sink;
    logic             mr_resp;
    logic             slv_bvalid;
    axicb_pkg::id_t   slv_bid;
    axicb_pkg::resp_t slv_bresp;

    ////////////////////
    // Write address
    ////////////////////

    assign aw_routed   = |i_target;
    assign o_s_awvalid = i_target & {NB{i_awvalid & ~i_wfifo_full}};
    assign o_awready   = aw_routed ? (|(i_target & i_s_awready) & ~i_wfifo_full) : mr_pulse;

    // One-cycle fake ready for an undefined or forbidden address
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mr_pulse <= 1'b0;
        end else if (mr_pulse) begin
            mr_pulse <= 1'b0;
        end else if (i_awvalid && !aw_routed && !i_bfifo_full && !i_wfifo_full) begin
            mr_pulse <= 1'b1;
        end
    end

    // Zero mask goes in on a misroute, the ID waits for its DECERR
    assign o_wfifo_push = i_awvalid & o_awready;
    assign o_bfifo_push = mr_pulse;

    ////////////////////
    // Write data
    ////////////////////

    assign w_active   = ~i_wfifo_empty;
    assign w_sink     = w_active & ~|i_w_target;
    assign o_s_wvalid = i_w_target & {NB{i_wvalid & w_active}};
    assign o_s_wlast  = i_w_target & {NB{i_wlast & w_active}};

    assign o_wready     = w_sink | (w_active & |(i_w_target & i_s_wready));
    assign o_wfifo_pull = i_wvalid & o_wready & i_wlast;

    ////////////////////
    // Write response
    ////////////////////

    assign mr_resp = ~i_bfifo_empty;

    // Granted slave response
    always_comb begin
        slv_bvalid = |(i_grant & i_s_bvalid);
        slv_bid    = '0;
        slv_bresp  = axicb_pkg::RESP_OKAY;
        for (int i = 0; i < NB; i++) begin
            if (i_grant[i]) begin
                slv_bid   = i_s_bid[i*IW +: IW];
                slv_bresp = i_s_bresp[i*2 +: 2];
            end
        end
    end

    assign o_bvalid = mr_resp | slv_bvalid;
    assign o_bid    = mr_resp ? i_bfifo_id : slv_bid;
    assign o_bresp  = mr_resp ? axicb_pkg::RESP_DECERR : slv_bresp;

    // Slaves wait while a DECERR is pending
    assign o_s_bready   = i_grant & {NB{i_bready & ~mr_resp}};
    assign o_bfifo_pull = mr_resp & i_bready;
    assign o_arb_en     = slv_bvalid & i_bready & ~mr_resp;

    // A misrouted request must be the one that gets the fake ready
    assert property (@(posedge aclk) disable iff (!aresetn)
        mr_pulse |-> (i_awvalid && !aw_routed && $stable(i_awid)))
    else $error("write ctrl: misroute pulse without its request");

endmodule

//--- hw/axicb_write_switch.sv
// Write side of one master's crossbar switch, no read channels
// Up to 8 writes in flight, 4 of them misrouted

`timescale 1ns/1ps

module axicb_write_switch #(
    parameter logic [axicb_pkg::SLV_NB*axicb_pkg::ADDR_W-1:0] SLV_START = {
        16'd12288, 16'd8192, 16'd4096, 16'd0
    },
    parameter logic [axicb_pkg::SLV_NB*axicb_pkg::ADDR_W-1:0] SLV_END = {
        16'd16383, 16'd12287, 16'd8191, 16'd4095
    },
    parameter axicb_pkg::slv_mask_t MST_ROUTES = 4'b1111
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    // Master side
    input  logic                 i_awvalid,
    output logic                 o_awready,
    input  axicb_pkg::addr_t     i_awaddr,
    input  axicb_pkg::id_t       i_awid,
    input  logic                 i_wvalid,
    output logic                 o_wready,
    input  logic                 i_wlast,
    input  logic [axicb_pkg::DATA_W-1:0] i_wdata,
    output logic                 o_bvalid,
    input  logic                 i_bready,
    output axicb_pkg::id_t       o_bid,
    output axicb_pkg::resp_t     o_bresp,
    // Slave side
    output axicb_pkg::slv_mask_t o_s_awvalid,
    input  axicb_pkg::slv_mask_t i_s_awready,
    output axicb_pkg::addr_t     o_s_awaddr,
    output axicb_pkg::id_t       o_s_awid,
    output axicb_pkg::slv_mask_t o_s_wvalid,
    input  axicb_pkg::slv_mask_t i_s_wready,
    output axicb_pkg::slv_mask_t o_s_wlast,
    output logic [axicb_pkg::DATA_W-1:0] o_s_wdata,
    input  axicb_pkg::slv_mask_t i_s_bvalid,
    output axicb_pkg::slv_mask_t o_s_bready,
    input  logic [axicb_pkg::SLV_NB*axicb_pkg::ID_W-1:0] i_s_bid,
    input  logic [axicb_pkg::SLV_NB*2-1:0]               i_s_bresp
);

    axicb_pkg::slv_mask_t aw_target;
    axicb_pkg::slv_mask_t w_target;
    axicb_pkg::slv_mask_t b_grant;
    axicb_pkg::id_t       bfifo_id;
    logic                 wfifo_push;
    logic                 wfifo_pull;
    logic                 wfifo_full;
    logic                 wfifo_empty;
    logic                 bfifo_push;
    logic                 bfifo_pull;
    logic                 bfifo_full;
    logic                 bfifo_empty;
    logic                 arb_en;

    // Payload broadcast to all slaves
    assign o_s_awaddr = i_awaddr;
    assign o_s_awid   = i_awid;
    assign o_s_wdata  = i_wdata;

    axicb_addr_decoder #(
        .SLV_START  (SLV_START),
        .SLV_END    (SLV_END),
        .MST_ROUTES (MST_ROUTES)
    ) u_decoder (
        .i_addr   (i_awaddr),
        .o_target (aw_target)
    );

    // Slave targeted by each accepted AW, in order
    axicb_sync_fifo #(
        .payload_t (axicb_pkg::slv_mask_t),
        .DEPTH     (8)
    ) u_wfifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (wfifo_push),
        .i_data  (aw_target),
        .i_pull  (wfifo_pull),
        .o_data  (w_target),
        .o_full  (wfifo_full),
        .o_empty (wfifo_empty)
    );

    // IDs of writes owed a DECERR
    axicb_sync_fifo #(
        .payload_t (axicb_pkg::id_t),
        .DEPTH     (4)
    ) u_bfifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (bfifo_push),
        .i_data  (i_awid),
        .i_pull  (bfifo_pull),
        .o_data  (bfifo_id),
        .o_full  (bfifo_full),
        .o_empty (bfifo_empty)
    );

    axicb_round_robin #(
        .REQ_NB (axicb_pkg::SLV_NB)
    ) u_b_arb (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_en    (arb_en),
        .i_req   (i_s_bvalid),
        .o_grant (b_grant)
    );

    axicb_write_ctrl u_ctrl (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_awvalid     (i_awvalid),
        .i_awid        (i_awid),
        .i_target      (aw_target),
        .o_awready     (o_awready),
        .i_wvalid      (i_wvalid),
        .i_wlast       (i_wlast),
        .o_wready      (o_wready),
        .o_bvalid      (o_bvalid),
        .i_bready      (i_bready),
        .o_bid         (o_bid),
        .o_bresp       (o_bresp),
        .o_s_awvalid   (o_s_awvalid),
        .i_s_awready   (i_s_awready),
        .o_s_wvalid    (o_s_wvalid),
        .o_s_wlast     (o_s_wlast),
        .i_s_wready    (i_s_wready),
        .i_s_bvalid    (i_s_bvalid),
        .o_s_bready    (o_s_bready),
        .i_s_bid       (i_s_bid),
        .i_s_bresp     (i_s_bresp),
        .o_wfifo_push  (wfifo_push),
        .o_wfifo_pull  (wfifo_pull),
        .i_wfifo_full  (wfifo_full),
        .i_wfifo_empty (wfifo_empty),
        .i_w_target    (w_target),
        .o_bfifo_push  (bfifo_push),
        .o_bfifo_pull  (bfifo_pull),
        .i_bfifo_full  (bfifo_full),
        .i_bfifo_empty (bfifo_empty),
        .i_bfifo_id    (bfifo_id),
        .o_arb_en      (arb_en),
        .i_grant       (b_grant)
    );

endmodule

//--- run.sh
#!/bin/sh
# Compile the write switch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_write_switch \
    -f filelist.f \
    --Mdir obj_dir

./obj_dir/Vtb_write_switch

//--- test/tb_clock_gen.sv
// Free-running clock; reset released 1 ns after the last reset edge

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic o_aclk,
    output logic o_aresetn
);

    initial begin
        o_aclk = 1'b0;
        forever begin
            #(PERIOD / 2) o_aclk = ~o_aclk;
        end
    end

    initial begin
        o_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_aclk);
        #1 o_aresetn = 1'b1;
    end

endmodule

//--- test/tb_write_switch.sv
// Slave 2 is forbidden and 16384 and up is undefined; IDs repeat every 16 writes
// Inputs change 1 ns after the rising edge, handshakes are sampled at the falling edge

`timescale 1ns/1ps

module tb_write_switch;

    localparam int N_WRITES        = 60;
    localparam int CLK_PERIOD      = 100;
    localparam int WIN_SIZE        = 4096;
    localparam int NB              = axicb_pkg::SLV_NB;
    localparam int IW              = axicb_pkg::ID_W;
    localparam int WATCHDOG_CYCLES = N_WRITES * 40;
    localparam axicb_pkg::slv_mask_t ROUTES = 4'b1011;

    typedef struct packed {
        logic             routed;
        logic [1:0]       slave;
        axicb_pkg::resp_t resp;
    } exp_t;

    logic                                 aclk;
    logic                                 aresetn;
    logic                                 i_awvalid;
    logic                                 o_awready;
    axicb_pkg::addr_t                     i_awaddr;
    axicb_pkg::id_t                       i_awid;
    logic                                 i_wvalid;
    logic                                 o_wready;
    logic                                 i_wlast;
    logic [axicb_pkg::DATA_W-1:0]         i_wdata;
    logic                                 o_bvalid;
    logic                                 i_bready;
    axicb_pkg::id_t                       o_bid;
    axicb_pkg::resp_t                     o_bresp;
    axicb_pkg::slv_mask_t                 o_s_awvalid;
    axicb_pkg::slv_mask_t                 i_s_awready;
    axicb_pkg::addr_t                     o_s_awaddr;
    axicb_pkg::id_t                       o_s_awid;
    axicb_pkg::slv_mask_t                 o_s_wvalid;
    axicb_pkg::slv_mask_t                 i_s_wready;
    axicb_pkg::slv_mask_t                 o_s_wlast;
    logic [axicb_pkg::DATA_W-1:0]         o_s_wdata;
    axicb_pkg::slv_mask_t                 i_s_bvalid;
    axicb_pkg::slv_mask_t                 o_s_bready;
    logic [NB*IW-1:0]                     i_s_bid;
    logic [NB*2-1:0]                      i_s_bresp;

    // Write table, built once at time 0
    axicb_pkg::addr_t             wr_addr [N_WRITES];
    axicb_pkg::id_t               wr_id   [N_WRITES];
    int                           wr_len  [N_WRITES];
    logic [axicb_pkg::DATA_W-1:0] wr_data [N_WRITES][4];
    exp_t                         wr_exp  [N_WRITES];

    bit  aw_done    [N_WRITES];
    bit  b_done     [N_WRITES];
    int  recv_beats [N_WRITES];
    int  aw_idx;
    int  w_idx;
    int  b_count;
    bit  w_finished;
    bit  go;

    // Per-slave bookkeeping of the models
    int  aw_q [NB][$];
    int  b_q  [NB][$];
    int  beat [NB];

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) u_clk (
        .o_aclk    (aclk),
        .o_aresetn (aresetn)
    );

    axicb_write_switch #(
        .MST_ROUTES (ROUTES)
    ) dut0 (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_awaddr    (i_awaddr),
        .i_awid      (i_awid),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .i_wlast     (i_wlast),
        .i_wdata     (i_wdata),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .o_bid       (o_bid),
        .o_bresp     (o_bresp),
        .o_s_awvalid (o_s_awvalid),
        .i_s_awready (i_s_awready),
        .o_s_awaddr  (o_s_awaddr),
        .o_s_awid    (o_s_awid),
        .o_s_wvalid  (o_s_wvalid),
        .i_s_wready  (i_s_wready),
        .o_s_wlast   (o_s_wlast),
        .o_s_wdata   (o_s_wdata),
        .i_s_bvalid  (i_s_bvalid),
        .o_s_bready  (o_s_bready),
        .i_s_bid     (i_s_bid),
        .i_s_bresp   (i_s_bresp)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("MISMATCH at %0t ns: %s", $time, msg));
    endtask

    // 4 KiB windows from 0, route mask applied, nothing above the last window
    function automatic exp_t expected_resp(input axicb_pkg::addr_t addr);
        exp_t r;
        int   win;
        win      = int'(addr) / WIN_SIZE;
        r.routed = 1'b0;
        r.slave  = 2'd0;
        if (win < NB) begin
            r.routed = ROUTES[win];
            r.slave  = 2'(win);
        end
        r.resp = r.routed ? axicb_pkg::RESP_OKAY : axicb_pkg::RESP_DECERR;
        return r;
    endfunction

    function automatic axicb_pkg::slv_mask_t target_mask(input exp_t e, input logic valid);
        axicb_pkg::slv_mask_t m;
        m = '0;
        if (valid && e.routed) begin
            m[e.slave] = 1'b1;
        end
        return m;
    endfunction

    ////////////////////
    // Master side
    ////////////////////

    initial begin : main_sequence
        int region;
        go = 1'b0;
        void'($urandom(66));
        for (int k = 0; k < N_WRITES; k++) begin
            region = int'($urandom_range(0, 4));
            if (region < NB) begin
                wr_addr[k] = axicb_pkg::addr_t'(region * WIN_SIZE
                                                + int'($urandom_range(0, WIN_SIZE - 1)));
            end else begin
                wr_addr[k] = axicb_pkg::addr_t'($urandom_range(16384, 65535));
            end
            wr_id[k]  = axicb_pkg::id_t'(k % 16);
            wr_len[k] = int'($urandom_range(1, 4));
            for (int b = 0; b < 4; b++) begin
                wr_data[k][b] = $urandom;
            end
            wr_exp[k] = expected_resp(wr_addr[k]);
        end
        @(posedge aresetn);
        // Idle outputs with no traffic
        repeat (5) begin
            @(negedge aclk);
            assert (!o_bvalid && o_s_awvalid == '0 && o_s_wvalid == '0)
            else report_mismatch("valid output raised after reset without traffic");
        end
        go = 1'b1;
        wait (b_count == N_WRITES && w_finished);
        for (int k = 0; k < N_WRITES; k++) begin
            assert (recv_beats[k] == (wr_exp[k].routed ? wr_len[k] : 0))
            else report_mismatch($sformatf("write %0d delivered %0d beats to slaves",
                                           k, recv_beats[k]));
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : aw_master
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_awid    = '0;
        aw_idx    = 0;
        wait (go);
        @(posedge aclk);
        #1;
        for (int k = 0; k < N_WRITES; k++) begin
            // Keep outstanding IDs unique
            while (k >= 16 && !b_done[k-16]) begin
                @(posedge aclk);
                #1;
            end
            i_awvalid = 1'b1;
            i_awaddr  = wr_addr[k];
            i_awid    = wr_id[k];
            aw_idx    = k;
            @(negedge aclk);
            while (!o_awready) begin
                @(negedge aclk);
            end
            aw_done[k] = 1'b1;
            @(posedge aclk);
            #1;
            i_awvalid = 1'b0;
            if ($urandom_range(0, 3) == 0) begin
                @(posedge aclk);
                #1;
            end
        end
    end

    initial begin : w_master
        i_wvalid   = 1'b0;
        i_wlast    = 1'b0;
        i_wdata    = '0;
        w_idx      = 0;
        w_finished = 1'b0;
        wait (go);
        @(posedge aclk);
        #1;
        for (int k = 0; k < N_WRITES; k++) begin
            for (int b = 0; b < wr_len[k]; b++) begin
                i_wvalid = 1'b1;
                i_wdata  = wr_data[k][b];
                i_wlast  = (b == wr_len[k] - 1);
                w_idx    = k;
                @(negedge aclk);
                while (!o_wready) begin
                    @(negedge aclk);
                end
                @(posedge aclk);
                #1;
                i_wvalid = 1'b0;
            end
        end
        w_finished = 1'b1;
    end

    ////////////////////
    // Slave models
    ////////////////////

    initial begin : slave_models
        int                   k;
        axicb_pkg::slv_mask_t b_taken;
        i_s_awready = '0;
        i_s_wready  = '0;
        i_s_bvalid  = '0;
        i_s_bid     = '0;
        i_s_bresp   = '0;
        forever begin
            @(negedge aclk);
            b_taken = '0;
            for (int s = 0; s < NB; s++) begin
                if (o_s_awvalid[s] && i_s_awready[s]) begin
                    assert (o_s_awaddr == wr_addr[aw_idx] && o_s_awid == wr_id[aw_idx])
                    else report_mismatch($sformatf("slave %0d got AW %h id %h", s,
                                                   o_s_awaddr, o_s_awid));
                    aw_q[s].push_back(aw_idx);
                end
                if (o_s_wvalid[s] && i_s_wready[s]) begin
                    assert (aw_q[s].size() > 0)
                    else abort_run($sformatf("slave %0d received W data before any AW", s));
                    k = aw_q[s][0];
                    assert (k == w_idx)
                    else report_mismatch($sformatf("slave %0d got beats of write %0d, not %0d",
                                                   s, k, w_idx));
                    assert (o_s_wdata == wr_data[k][beat[s]])
                    else report_mismatch($sformatf("write %0d beat %0d data %h", k, beat[s],
                                                   o_s_wdata));
                    assert (o_s_wlast[s] == (beat[s] == wr_len[k] - 1))
                    else report_mismatch($sformatf("write %0d beat %0d wlast %b", k, beat[s],
                                                   o_s_wlast[s]));
                    recv_beats[k]++;
                    beat[s]++;
                    if (o_s_wlast[s]) begin
                        void'(aw_q[s].pop_front());
                        b_q[s].push_back(k);
                        beat[s] = 0;
                    end
                end
                if (i_s_bvalid[s] && o_s_bready[s]) begin
                    void'(b_q[s].pop_front());
                    b_taken[s] = 1'b1;
                end
            end
            @(posedge aclk);
            #1;
            for (int s = 0; s < NB; s++) begin
                i_s_awready[s] = ($urandom_range(0, 1) == 1);
                i_s_wready[s]  = ($urandom_range(0, 3) != 0);
                if (b_taken[s]) begin
                    i_s_bvalid[s] = 1'b0;
                end
                // A raised B holds until taken
                if (!i_s_bvalid[s] && b_q[s].size() > 0 && $urandom_range(0, 1) == 1) begin
                    i_s_bvalid[s]         = 1'b1;
                    i_s_bid[s*IW +: IW]   = wr_id[b_q[s][0]];
                    i_s_bresp[s*2 +: 2]   = axicb_pkg::RESP_OKAY;
                end
            end
        end
    end

    ////////////////////
    // Comparison
    ////////////////////

    initial begin : compare_results
        axicb_pkg::slv_mask_t mask;
        int                   found;
        i_bready = 1'b0;
        b_count  = 0;
        forever begin
            @(negedge aclk);
            if (aresetn) begin
                mask = target_mask(expected_resp(i_awaddr), i_awvalid);
                assert ((o_s_awvalid & ~mask) == '0)
                else report_mismatch($sformatf("o_s_awvalid %b for address %h",
                                               o_s_awvalid, i_awaddr));
                mask = target_mask(wr_exp[w_idx], i_wvalid);
                assert ((o_s_wvalid & ~mask) == '0)
                else report_mismatch($sformatf("o_s_wvalid %b during write %0d",
                                               o_s_wvalid, w_idx));
                if (o_bvalid && i_bready) begin
                    found = -1;
                    for (int k = 0; k < N_WRITES; k++) begin
                        if (aw_done[k] && !b_done[k] && wr_id[k] == o_bid) begin
                            found = k;
                        end
                    end
                    assert (found >= 0)
                    else report_mismatch($sformatf("B with ID %h matches no open write", o_bid));
                    assert (o_bresp == wr_exp[found].resp)
                    else report_mismatch($sformatf("write %0d response %0d, expected %0d",
                                                   found, o_bresp, wr_exp[found].resp));
                    b_done[found] = 1'b1;
                    b_count++;
                end
            end
            @(posedge aclk);
            #1;
            i_bready = ($urandom_range(0, 1) == 1);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before all writes completed");
    end

endmodule
